// ==== list.f ====
+incdir+include
hw/vlsu_pkg.sv
hw/vlsu_reorder_buffer.sv
hw/vlsu_addr_gen.sv
hw/vlsu.sv
hw/vlsu_vrf.sv
hw/vlsu_top.sv
dv/tb_clk_gen.sv
dv/vlsu_mem_model.sv
dv/vlsu_assert.sv
dv/tb_vlsu_top.sv

// ==== dv/tb_vlsu_top.sv ====
// Directed tests that load a vector, store it back and compare the memory log
// Inputs change 1 ns after the rising edge and outputs are read there too
// Memory is word addressed modulo 1024 words

`timescale 1ns/1ps

module tb_vlsu_top;
  import vlsu_pkg::*;

  localparam int unsigned TimeoutCycles = 2000;
  localparam int unsigned MemWords      = 1024;

  logic        clk;
  logic        rst;
  lsu_req_t    lsu_req;
  logic        req_valid;
  logic        req_ready;
  logic        rsp_valid;
  lsu_rsp_t    rsp;
  logic        mem_valid;
  logic        mem_ready;
  mem_req_t    mem_req;
  logic        mem_result_valid;
  mem_result_t mem_result;

  tb_clk_gen u_clk_gen (
    .clk_o(clk),
    .rst_o(rst)
  );

  vlsu_top u_dut (
    .clk_i             (clk),
    .rst_i             (rst),
    .lsu_req_i         (lsu_req),
    .req_valid_i       (req_valid),
    .req_ready_o       (req_ready),
    .rsp_valid_o       (rsp_valid),
    .rsp_o             (rsp),
    .mem_valid_o       (mem_valid),
    .mem_ready_i       (mem_ready),
    .mem_req_o         (mem_req),
    .mem_result_valid_i(mem_result_valid),
    .mem_result_i      (mem_result)
  );

  vlsu_mem_model #(
    .Words(MemWords)
  ) u_mem (
    .clk_i             (clk),
    .rst_i             (rst),
    .mem_valid_i       (mem_valid),
    .mem_ready_o       (mem_ready),
    .mem_req_i         (mem_req),
    .mem_result_valid_o(mem_result_valid),
    .mem_result_o      (mem_result)
  );

  ////////////////////////////////////////////////////////////
  // Failure reporting and compare tasks
  ////////////////////////////////////////////////////////////

  task automatic stop_with_failure(input string what);
    $display("%s", what);
    $display("Verification failed");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic compare_elem(input string name, input elem_t got, input elem_t exp);
    if (got !== exp) begin
      stop_with_failure($sformatf("[ERROR] time %0t %s expected %h actual %h",
                                  $time, name, exp, got));
    end
  endtask

  task automatic compare_addr(input string name, input addr_t got, input addr_t exp);
    if (got !== exp) begin
      stop_with_failure($sformatf("[ERROR] time %0t %s expected %h actual %h",
                                  $time, name, exp, got));
    end
  endtask

  task automatic compare_rsp(input string name, input lsu_rsp_t got, input lsu_rsp_t exp);
    if (got !== exp) begin
      stop_with_failure($sformatf(
          "[ERROR] time %0t %s expected vd %0d load %b actual vd %0d load %b",
          $time, name, exp.vd, exp.is_load, got.vd, got.is_load));
    end
  endtask

  task automatic compare_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      stop_with_failure($sformatf("[ERROR] time %0t %s expected %b actual %b",
                                  $time, name, exp, got));
    end
  endtask

  // Bound assertions count their failures
  always @(negedge clk) begin
    if (u_dut.u_vlsu.u_assert.fail_count != 0) begin
      stop_with_failure("A bound assertion on the DUT failed");
    end
  end

  ////////////////////////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////////////////////////

  function automatic int unsigned mem_word(addr_t addr);
    return (addr >> 2) % MemWords;
  endfunction

  // Element address from the instruction rules
  function automatic addr_t elem_addr(lsu_op_e op, addr_t base, stride_t stride, int idx);
    if (op == LSU_VLSE || op == LSU_VSSE) begin
      return base + addr_t'(stride * idx);
    end
    return base + addr_t'(idx * 4);
  endfunction

  // Background pattern from the full byte address
  task automatic fill_memory();
    addr_t a;
    for (int i = 0; i < MemWords; i++) begin
      a = addr_t'(i) << 2;
      u_mem.mem[i] = {~a[15:0], a[15:0]} ^ 32'h3c96_0000;
    end
  endtask

  task automatic set_memory_timing(input int unsigned stall, input int unsigned span,
                                   input int unsigned release_rate, input bit reverse);
    u_mem.stall_pct    = stall;
    u_mem.span_max     = span;
    u_mem.release_pct  = release_rate;
    u_mem.reverse_mode = reverse;
  endtask

  task automatic send_instr(input lsu_op_e op, input vreg_idx_t vd, input addr_t base,
                            input stride_t stride, input vl_t vl);
    int unsigned cycles;
    cycles = 0;
    while (req_ready !== 1'b1) begin
      if (cycles == TimeoutCycles) begin
        stop_with_failure("Timed out waiting for req_ready_o");
      end
      @(posedge clk);
      #1;
      cycles++;
    end
    lsu_req.op     = op;
    lsu_req.vd     = vd;
    lsu_req.base   = base;
    lsu_req.stride = stride;
    lsu_req.vl     = vl;
    req_valid      = 1'b1;
    @(posedge clk);
    #1;
    req_valid = 1'b0;
  endtask

  task automatic wait_rsp(input lsu_rsp_t exp);
    int unsigned cycles;
    cycles = 0;
    while (rsp_valid !== 1'b1) begin
      if (cycles == TimeoutCycles) begin
        stop_with_failure("Timed out waiting for rsp_valid_o");
      end
      @(posedge clk);
      #1;
      cycles++;
    end
    compare_rsp("rsp_o", rsp, exp);
    @(posedge clk);
    #1;
  endtask

  // Load vl elements into vd, store them back out, then check the write log
  task automatic round_trip(input lsu_op_e ld_op, input lsu_op_e st_op, input vreg_idx_t vd,
                            input addr_t src, input stride_t src_stride,
                            input addr_t dst, input stride_t dst_stride, input vl_t vl);
    elem_t    exp_q [$];
    elem_t    value;
    addr_t    addr;
    lsu_rsp_t rsp_exp;
    for (int i = 0; i < vl; i++) begin
      value = $urandom;
      exp_q.push_back(value);
      u_mem.mem[mem_word(elem_addr(ld_op, src, src_stride, i))] = value;
    end
    u_mem.wr_addr_q.delete();
    u_mem.wr_data_q.delete();
    rsp_exp.vd      = vd;
    rsp_exp.is_load = 1'b1;
    send_instr(ld_op, vd, src, src_stride, vl);
    wait_rsp(rsp_exp);
    rsp_exp.is_load = 1'b0;
    send_instr(st_op, vd, dst, dst_stride, vl);
    wait_rsp(rsp_exp);
    if (u_mem.wr_addr_q.size() != vl) begin
      stop_with_failure($sformatf("Load and store of %0d elements made %0d memory writes",
                                  vl, u_mem.wr_addr_q.size()));
    end
    for (int i = 0; i < vl; i++) begin
      addr = elem_addr(st_op, dst, dst_stride, i);
      compare_addr("mem_req_o.addr", u_mem.wr_addr_q[i], addr);
      compare_elem("mem_req_o.wdata", u_mem.wr_data_q[i], exp_q[i]);
      compare_elem("memory word", u_mem.mem[mem_word(addr)], exp_q[i]);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Tests
  ////////////////////////////////////////////////////////////

  task automatic check_reset_state();
    compare_bit("req_ready_o", req_ready, 1'b1);
    compare_bit("mem_valid_o", mem_valid, 1'b0);
    compare_bit("rsp_valid_o", rsp_valid, 1'b0);
  endtask

  task automatic run_unit_stride();
    set_memory_timing(10, 2, 60, 1'b0);
    round_trip(LSU_VLE, LSU_VSE, 3'd1, 32'h0000_0100, '0, 32'h0000_0400, '0, 4'd8);
    round_trip(LSU_VLE, LSU_VSE, 3'd6, 32'h0000_0180, '0, 32'h0000_0480, '0, 4'd3);
  endtask

  task automatic run_strided();
    set_memory_timing(10, 2, 60, 1'b0);
    round_trip(LSU_VLSE, LSU_VSSE, 3'd2, 32'h0000_0800, 32'sd12,
               32'h0000_0c00, -32'sd8, 4'd7);
    round_trip(LSU_VLSE, LSU_VSSE, 3'd5, 32'h0000_0700, -32'sd16,
               32'h0000_0200, 32'sd20, 4'd5);
  endtask

  task automatic run_out_of_order();
    set_memory_timing(0, 1, 20, 1'b1);
    round_trip(LSU_VLE, LSU_VSE, 3'd3, 32'h0000_0500, '0, 32'h0000_0600, '0, 4'd8);
    set_memory_timing(0, 1, 30, 1'b0);
    round_trip(LSU_VLSE, LSU_VSE, 3'd7, 32'h0000_0900, 32'sd8, 32'h0000_0d00, '0, 4'd8);
  endtask

  task automatic run_back_pressure();
    set_memory_timing(40, 12, 50, 1'b0);
    round_trip(LSU_VLE, LSU_VSE, 3'd4, 32'h0000_0a00, '0, 32'h0000_0e00, '0, 4'd8);
    round_trip(LSU_VLSE, LSU_VSSE, 3'd0, 32'h0000_0b00, 32'sd4,
               32'h0000_0f80, -32'sd4, 4'd6);
    set_memory_timing(0, 1, 100, 1'b0);
  endtask

  task automatic run_zero_length();
    int unsigned seen;
    lsu_rsp_t    rsp_exp;
    seen            = u_mem.valid_seen;
    rsp_exp.vd      = 3'd5;
    rsp_exp.is_load = 1'b1;
    send_instr(LSU_VLE, 3'd5, 32'h0000_0100, '0, 4'd0);
    wait_rsp(rsp_exp);
    rsp_exp.is_load = 1'b0;
    send_instr(LSU_VSSE, 3'd5, 32'h0000_0200, 32'sd16, 4'd0);
    wait_rsp(rsp_exp);
    if (u_mem.valid_seen != seen) begin
      stop_with_failure("Zero-length instruction sent a memory request");
    end
  endtask

  initial begin
    int unsigned cycles;
    void'($urandom(35342));
    lsu_req   = '0;
    req_valid = 1'b0;
    fill_memory();
    // Reset is sampled on the edge, where it is stable
    cycles = 0;
    do begin
      if (cycles == 16) begin
        stop_with_failure("Reset was never released");
      end
      @(posedge clk);
      cycles++;
    end while (rst !== 1'b0);
    #1;
    check_reset_state();
    run_unit_stride();
    run_strided();
    run_out_of_order();
    run_back_pressure();
    run_zero_length();
    if (u_dut.u_vlsu.u_assert.fail_count == 0) begin
      $display("Verification passed");
      $finish;
    end else begin
      stop_with_failure("A bound assertion on the DUT failed");
    end
  end

endmodule

// ==== dv/vlsu_assert.sv ====
// Bound into every vlsu instance; port names follow the vlsu signals
// fail_count holds the number of failed properties so far

`timescale 1ns/1ps
`include "vlsu_settings.svh"

module vlsu_assert (
  input logic                           clk_i,
  input logic                           rst_i,
  input logic                           req_valid_i,
  input logic                           req_ready_i,
  input logic                           rsp_valid_i,
  input logic                           mem_valid_i,
  input logic                           mem_ready_i,
  input vlsu_pkg::mem_req_t             mem_req_i,
  input logic                           rob_push_i,
  input vlsu_pkg::rob_id_t              rob_push_id_i,
  input logic [`VLSU_ROB_DEPTH-1:0]     rob_valid_i
);

  int unsigned fail_count = 0;

  // Set by an accepted instruction, cleared by its response
  logic busy_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      busy_q <= 1'b0;
    end else if (req_valid_i && req_ready_i) begin
      busy_q <= 1'b1;
    end else if (rsp_valid_i) begin
      busy_q <= 1'b0;
    end
  end

  // Request held stable while stalled
  assert property (@(posedge clk_i) disable iff (rst_i)
    mem_valid_i && !mem_ready_i |=> mem_valid_i && $stable(mem_req_i))
  else begin
    fail_count++;
    $error("Memory request dropped or changed under stall");
  end

  assert property (@(posedge clk_i) disable iff (rst_i)
    rob_push_i |-> !rob_valid_i[rob_push_id_i])
  else begin
    fail_count++;
    $error("Reorder buffer push to a slot that already holds data");
  end

  assert property (@(posedge clk_i) disable iff (rst_i) busy_q |-> !req_ready_i)
  else begin
    fail_count++;
    $error("req_ready_o high while an instruction is in progress");
  end

endmodule

bind vlsu vlsu_assert u_assert (
  .clk_i        (clk_i),
  .rst_i        (rst_i),
  .req_valid_i  (req_valid_i),
  .req_ready_i  (req_ready_o),
  .rsp_valid_i  (rsp_valid_o),
  .mem_valid_i  (mem_valid_o),
  .mem_ready_i  (mem_ready_i),
  .mem_req_i    (mem_req_o),
  .rob_push_i   (rob_push),
  .rob_push_id_i(rob_push_id),
  .rob_valid_i  (u_rob.valid_q)
);

// ==== dv/vlsu_mem_model.sv ====
// Word memory behind the single memory port, addresses taken modulo Words
// Load data is read when the request is accepted; results come back later
// and out of order; knobs are set by the testbench through hierarchy

`timescale 1ns/1ps

module vlsu_mem_model #(
  parameter int unsigned Words = 1024
) (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic                  mem_valid_i,
  output logic                  mem_ready_o,
  input  vlsu_pkg::mem_req_t    mem_req_i,
  output logic                  mem_result_valid_o,
  output vlsu_pkg::mem_result_t mem_result_o
);
  import vlsu_pkg::*;

  elem_t       mem [Words];
  // Log of every accepted write, in acceptance order
  addr_t       wr_addr_q [$];
  elem_t       wr_data_q [$];
  int unsigned valid_seen = 0;

  // Stall and release knobs, percentages out of 100
  int unsigned stall_pct    = 0;
  int unsigned span_max     = 1;
  int unsigned release_pct  = 100;
  bit          reverse_mode = 1'b0;

  mem_result_t pend_q [$];
  int unsigned span = 0;

  function automatic int unsigned word_of(addr_t addr);
    return (addr >> 2) % Words;
  endfunction

  initial begin
    mem_result_t res;
    int unsigned pick;
    mem_ready_o        = 1'b0;
    mem_result_valid_o = 1'b0;
    mem_result_o       = '0;
    forever begin
      @(posedge clk_i);
      if (rst_i) begin
        pend_q.delete();
        span = 0;
        #1;
        mem_ready_o        = 1'b0;
        mem_result_valid_o = 1'b0;
      end else begin
        if (mem_valid_i) begin
          valid_seen++;
        end
        if (mem_valid_i && mem_ready_o) begin
          if (mem_req_i.we) begin
            mem[word_of(mem_req_i.addr)] = mem_req_i.wdata;
            wr_addr_q.push_back(mem_req_i.addr);
            wr_data_q.push_back(mem_req_i.wdata);
          end else begin
            res.id    = mem_req_i.id;
            res.rdata = mem[word_of(mem_req_i.addr)];
            pend_q.push_back(res);
          end
        end
        #1;
        // Release at most one result per cycle, youngest first when reversing
        mem_result_valid_o = 1'b0;
        if (pend_q.size() != 0 && ($urandom % 100) < release_pct) begin
          pick = reverse_mode ? pend_q.size() - 1 : $urandom % pend_q.size();
          mem_result_o       = pend_q[pick];
          mem_result_valid_o = 1'b1;
          pend_q.delete(pick);
        end
        // Stall spans of random length
        if (span != 0) begin
          span--;
        end else if (($urandom % 100) < stall_pct) begin
          span = 1 + ($urandom % span_max);
        end
        mem_ready_o = (span == 0);
      end
    end
  end

endmodule

// ==== dv/tb_clk_gen.sv ====
// Free-running clock and a synchronous reset held for ResetCycles edges
// Reset is released a small delay after a rising edge

`timescale 1ns/1ps

module tb_clk_gen #(
  parameter real         PeriodNs    = 8.0,
  parameter int unsigned ResetCycles = 2
) (
  output logic clk_o,
  output logic rst_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PeriodNs / 2.0) clk_o = ~clk_o;
  end

  initial begin
    rst_o = 1'b1;
    repeat (ResetCycles) @(posedge clk_o);
    #1;
    rst_o = 1'b0;
  end

endmodule

// ==== hw/vlsu_top.sv ====
// Load/store unit with its local vector register file
// Loaded data is observable only by storing it back out to memory

`timescale 1ns/1ps

module vlsu_top (
  input  logic                  clk_i,
  input  logic                  rst_i,
  // Instruction request
  input  vlsu_pkg::lsu_req_t    lsu_req_i,
  input  logic                  req_valid_i,
  output logic                  req_ready_o,
  // Completion
  output logic                  rsp_valid_o,
  output vlsu_pkg::lsu_rsp_t    rsp_o,
  // Memory request
  output logic                  mem_valid_o,
  input  logic                  mem_ready_i,
  output vlsu_pkg::mem_req_t    mem_req_o,
  // Memory result
  input  logic                  mem_result_valid_i,
  input  vlsu_pkg::mem_result_t mem_result_i
);
  import vlsu_pkg::*;

  // Register file ports
  logic      vrf_re;
  vrf_addr_t vrf_raddr;
  elem_t     vrf_rdata;
  logic      vrf_rvalid;
  logic      vrf_we;
  vrf_wr_t   vrf_wr;

  vlsu u_vlsu (
    .clk_i             (clk_i),
    .rst_i             (rst_i),
    .req_i             (lsu_req_i),
    .req_valid_i       (req_valid_i),
    .req_ready_o       (req_ready_o),
    .rsp_valid_o       (rsp_valid_o),
    .rsp_o             (rsp_o),
    .mem_valid_o       (mem_valid_o),
    .mem_ready_i       (mem_ready_i),
    .mem_req_o         (mem_req_o),
    .mem_result_valid_i(mem_result_valid_i),
    .mem_result_i      (mem_result_i),
    .vrf_re_o          (vrf_re),
    .vrf_raddr_o       (vrf_raddr),
    .vrf_rdata_i       (vrf_rdata),
    .vrf_rvalid_i      (vrf_rvalid),
    .vrf_we_o          (vrf_we),
    .vrf_wr_o          (vrf_wr)
  );

  vlsu_vrf u_vrf (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .re_i    (vrf_re),
    .raddr_i (vrf_raddr),
    .rdata_o (vrf_rdata),
    .rvalid_o(vrf_rvalid),
    .we_i    (vrf_we),
    .wr_i    (vrf_wr)
  );

endmodule

// ==== hw/vlsu_vrf.sv ====
// One read port and one write port; read data follows one cycle after re_i
// A read and a write to the same word in one cycle returns the old word
// Contents come up undefined after reset

`timescale 1ns/1ps
`include "vlsu_settings.svh"

module vlsu_vrf (
  input  logic                clk_i,
  input  logic                rst_i,
  // Read port
  input  logic                re_i,
  input  vlsu_pkg::vrf_addr_t raddr_i,
  output vlsu_pkg::elem_t     rdata_o,
  output logic                rvalid_o,
  // Write port
  input  logic                we_i,
  input  vlsu_pkg::vrf_wr_t   wr_i
);
  import vlsu_pkg::*;

  localparam int unsigned Words = `VLSU_NR_VREGS * `VLSU_VLMAX;

  elem_t regs_q [Words];

  ////////////////////////////////////////////////////////////
  // Storage
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (we_i) begin
      regs_q[wr_i.waddr] <= wr_i.wdata;
    end
  end

  // Registered read data
  always_ff @(posedge clk_i) begin
    if (re_i) begin
      rdata_o <= regs_q[raddr_i];
    end
  end

  // Valid flag
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rvalid_o <= 1'b0;
    end else begin
      rvalid_o <= re_i;
    end
  end

endmodule

// ==== hw/vlsu.sv ====
// Handles one vector memory instruction at a time over a single memory port
// Load results may return in any order; the reorder buffer restores it
// Addresses are assumed word aligned and no exceptions are raised

`timescale 1ns/1ps
`include "vlsu_settings.svh"

module vlsu (
  input  logic                  clk_i,
  input  logic                  rst_i,
  // Instruction request
  input  vlsu_pkg::lsu_req_t    req_i,
  input  logic                  req_valid_i,
  output logic                  req_ready_o,
  // Completion
  output logic                  rsp_valid_o,
  output vlsu_pkg::lsu_rsp_t    rsp_o,
  // Memory request
  output logic                  mem_valid_o,
  input  logic                  mem_ready_i,
  output vlsu_pkg::mem_req_t    mem_req_o,
  // Memory result, loads only
  input  logic                  mem_result_valid_i,
  input  vlsu_pkg::mem_result_t mem_result_i,
  // Register file
  output logic                  vrf_re_o,
  output vlsu_pkg::vrf_addr_t   vrf_raddr_o,
  input  vlsu_pkg::elem_t       vrf_rdata_i,
  input  logic                  vrf_rvalid_i,
  output logic                  vrf_we_o,
  output vlsu_pkg::vrf_wr_t     vrf_wr_o
);
  import vlsu_pkg::*;

  typedef enum logic [1:0] {
    IDLE,
    RUN,
    DONE
  } state_e;

  state_e    state_q, state_d;
  lsu_req_t  req_q;
  vl_t       issue_q;
  vl_t       retire_q;
  rob_id_t   rd_id_q;

  logic      is_load;
  logic      running;
  logic      accept;
  logic      issue_left;
  logic      retire_last;
  logic      issue_fire;
  logic      retire_fire;
  logic      ld_issue;
  logic      st_send;

  // Reorder buffer
  rob_id_t   rob_tail_id;
  logic      rob_push;
  rob_id_t   rob_push_id;
  elem_t     rob_push_data;
  logic      rob_head_valid;
  elem_t     rob_head_data;
  logic      rob_full;
  logic      rob_empty;

  // Address generation
  addr_t     issue_mem_addr;
  vrf_addr_t issue_vrf_addr;
  addr_t     retire_mem_addr;
  vrf_addr_t retire_vrf_addr;

  assign is_load     = lsu_is_load(req_q.op);
  assign running     = (state_q == RUN);
  assign req_ready_o = (state_q == IDLE) && rob_empty;
  assign accept      = req_valid_i && req_ready_o;
  assign issue_left  = (issue_q < req_q.vl);
  assign retire_last = (vl_t'(retire_q + 1'b1) == req_q.vl);

  ////////////////////////////////////////////////////////////
  // Issue and retire control
  ////////////////////////////////////////////////////////////

  // Load: one memory request per element, each reserving an id
  assign ld_issue = running && is_load && issue_left && !rob_full;
  // Store: head of the buffer goes out as a write
  assign st_send  = running && !is_load && rob_head_valid;

  assign mem_valid_o = ld_issue || st_send;
  assign vrf_re_o    = running && !is_load && issue_left && !rob_full;
  assign vrf_we_o    = running && is_load && rob_head_valid;

  assign issue_fire  = is_load ? (ld_issue && mem_ready_i) : vrf_re_o;
  assign retire_fire = is_load ? vrf_we_o : (st_send && mem_ready_i);

  // Buffer is fed by memory results or by register reads
  assign rob_push      = is_load ? mem_result_valid_i : vrf_rvalid_i;
  assign rob_push_id   = is_load ? mem_result_i.id : rd_id_q;
  assign rob_push_data = is_load ? mem_result_i.rdata : vrf_rdata_i;

  vlsu_reorder_buffer #(
    .Depth(`VLSU_ROB_DEPTH)
  ) u_rob (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .id_req_i    (issue_fire),
    .id_o        (rob_tail_id),
    .push_i      (rob_push),
    .push_id_i   (rob_push_id),
    .push_data_i (rob_push_data),
    .pop_i       (retire_fire),
    .head_valid_o(rob_head_valid),
    .head_data_o (rob_head_data),
    .full_o      (rob_full),
    .empty_o     (rob_empty)
  );

  // Issue side addresses the memory for loads, the register file for stores
  vlsu_addr_gen u_addr_issue (
    .req_i     (req_q),
    .elem_i    (elem_idx_t'(issue_q)),
    .mem_addr_o(issue_mem_addr),
    .vrf_addr_o(issue_vrf_addr)
  );

  vlsu_addr_gen u_addr_retire (
    .req_i     (req_q),
    .elem_i    (elem_idx_t'(retire_q)),
    .mem_addr_o(retire_mem_addr),
    .vrf_addr_o(retire_vrf_addr)
  );

  always_comb begin
    mem_req_o.id    = is_load ? rob_tail_id : '0;
    mem_req_o.addr  = is_load ? issue_mem_addr : retire_mem_addr;
    mem_req_o.we    = !is_load;
    mem_req_o.wdata = is_load ? '0 : rob_head_data;
  end

  assign vrf_raddr_o    = issue_vrf_addr;
  assign vrf_wr_o.waddr = retire_vrf_addr;
  assign vrf_wr_o.wdata = rob_head_data;

  assign rsp_valid_o   = (state_q == DONE);
  assign rsp_o.vd      = req_q.vd;
  assign rsp_o.is_load = is_load;

  ////////////////////////////////////////////////////////////
  // Instruction FSM and counters
  ////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (accept) begin
          state_d = (req_i.vl == '0) ? DONE : RUN;
        end
      end
      RUN: begin
        if (retire_fire && retire_last) begin
          state_d = DONE;
        end
      end
      DONE:    state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q  <= IDLE;
      issue_q  <= '0;
      retire_q <= '0;
    end else begin
      state_q <= state_d;
      if (accept) begin
        issue_q  <= '0;
        retire_q <= '0;
      end else begin
        if (issue_fire) begin
          issue_q <= issue_q + 1'b1;
        end
        if (retire_fire) begin
          retire_q <= retire_q + 1'b1;
        end
      end
    end
  end

  // Instruction and the id of the register read in flight
  always_ff @(posedge clk_i) begin
    if (accept) begin
      req_q <= req_i;
    end
    if (vrf_re_o) begin
      rd_id_q <= rob_tail_id;
    end
  end

endmodule

// ==== hw/vlsu_addr_gen.sv ====
// Purely combinational; the memory address wraps modulo 2**32
// Strided forms take a signed byte stride, unit-stride forms step by 4

`timescale 1ns/1ps

module vlsu_addr_gen (
  input  vlsu_pkg::lsu_req_t  req_i,
  input  vlsu_pkg::elem_idx_t elem_i,
  output vlsu_pkg::addr_t     mem_addr_o,
  output vlsu_pkg::vrf_addr_t vrf_addr_o
);
  import vlsu_pkg::*;

  stride_t offset;

  always_comb begin
    if (req_i.op == LSU_VLSE || req_i.op == LSU_VSSE) begin
      // Element index is never negative
      offset = $signed({1'b0, elem_i}) * $signed(req_i.stride);
    end else begin
      offset = stride_t'(elem_i) << 2;
    end
    mem_addr_o = req_i.base + addr_t'(offset);
  end

  // Word address in the register file is {register, element}
  assign vrf_addr_o = {req_i.vd, elem_i};

endmodule

// ==== hw/vlsu_reorder_buffer.sv ====
// Ids are handed out in circular order; data may arrive for any id
// Pushing to an id that was never requested, or twice, corrupts the order
// Depth may not exceed 2**$bits(rob_id_t)

`timescale 1ns/1ps
`include "vlsu_settings.svh"

module vlsu_reorder_buffer #(
  parameter int unsigned Depth = `VLSU_ROB_DEPTH
) (
  input  logic              clk_i,
  input  logic              rst_i,
  // Id allocation
  input  logic              id_req_i,
  output vlsu_pkg::rob_id_t id_o,
  // Write side, any order
  input  logic              push_i,
  input  vlsu_pkg::rob_id_t push_id_i,
  input  vlsu_pkg::elem_t   push_data_i,
  // Read side, allocation order
  input  logic              pop_i,
  output logic              head_valid_o,
  output vlsu_pkg::elem_t   head_data_o,
  output logic              full_o,
  output logic              empty_o
);
  import vlsu_pkg::*;

  localparam int unsigned CntW = $clog2(Depth + 1);

  elem_t            data_q [Depth];
  logic [Depth-1:0] valid_q;
  rob_id_t          head_q;
  rob_id_t          tail_q;
  logic [CntW-1:0]  count_q;

  // Circular increment, also for depths that are not a power of two
  function automatic rob_id_t next_id(rob_id_t id);
    return (id == rob_id_t'(Depth - 1)) ? '0 : rob_id_t'(id + 1'b1);
  endfunction

  assign id_o         = tail_q;
  assign head_valid_o = valid_q[head_q];
  assign head_data_o  = data_q[head_q];
  assign full_o       = (count_q == CntW'(Depth));
  assign empty_o      = (count_q == '0);

  ////////////////////////////////////////////////////////////
  // Pointers, slot flags and occupancy
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      head_q  <= '0;
      tail_q  <= '0;
      count_q <= '0;
      valid_q <= '0;
    end else begin
      if (id_req_i) begin
        tail_q <= next_id(tail_q);
      end
      if (pop_i) begin
        head_q          <= next_id(head_q);
        valid_q[head_q] <= 1'b0;
      end
      // A push never targets the slot being popped
      if (push_i) begin
        valid_q[push_id_i] <= 1'b1;
      end
      if (id_req_i && !pop_i) begin
        count_q <= count_q + 1'b1;
      end else if (!id_req_i && pop_i) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  // Element storage
  always_ff @(posedge clk_i) begin
    if (push_i) begin
      data_q[push_id_i] <= push_data_i;
    end
  end

endmodule

// ==== hw/vlsu_pkg.sv ====
// Types shared by the vector load/store unit and its register file
// Elements are 32 bits and all addresses are assumed word aligned

`include "vlsu_settings.svh"

package vlsu_pkg;

  typedef logic [31:0]                          elem_t;
  typedef logic [31:0]                          addr_t;
  typedef logic signed [31:0]                   stride_t;
  typedef logic [$clog2(`VLSU_NR_VREGS)-1:0]    vreg_idx_t;
  typedef logic [$clog2(`VLSU_VLMAX + 1)-1:0]   vl_t;
  typedef logic [$clog2(`VLSU_VLMAX)-1:0]       elem_idx_t;
  typedef logic [$bits(vreg_idx_t)+$bits(elem_idx_t)-1:0] vrf_addr_t;
  typedef logic [$clog2(`VLSU_ROB_DEPTH)-1:0]   rob_id_t;

  // Vector memory operations
  typedef enum logic [1:0] {
    LSU_VLE  = 2'd0,
    LSU_VSE  = 2'd1,
    LSU_VLSE = 2'd2,
    LSU_VSSE = 2'd3
  } lsu_op_e;

  // Stride is ignored by the unit-stride operations
  typedef struct packed {
    lsu_op_e   op;
    vreg_idx_t vd;
    addr_t     base;
    stride_t   stride;
    vl_t       vl;
  } lsu_req_t;

  typedef struct packed {
    vreg_idx_t vd;
    logic      is_load;
  } lsu_rsp_t;

  typedef struct packed {
    rob_id_t id;
    addr_t   addr;
    logic    we;
    elem_t   wdata;
  } mem_req_t;

  typedef struct packed {
    rob_id_t id;
    elem_t   rdata;
  } mem_result_t;

  typedef struct packed {
    vrf_addr_t waddr;
    elem_t     wdata;
  } vrf_wr_t;

  function automatic logic lsu_is_load(lsu_op_e op);
    return (op == LSU_VLE) || (op == LSU_VLSE);
  endfunction

endpackage

// ==== include/vlsu_settings.svh ====
// Sizes of the vector load/store unit, fixed at build time
// VLSU_ROB_DEPTH may not exceed 2**$bits(rob_id_t) and sets the number of
// elements in flight at once

`ifndef VLSU_SETTINGS_SVH
`define VLSU_SETTINGS_SVH

// Number of architectural vector registers
`define VLSU_NR_VREGS 8

// Elements of 32 bits per vector register
`define VLSU_VLMAX 8

// Outstanding elements held in the reorder buffer
`define VLSU_ROB_DEPTH 4

`endif
